//--- flist.f
common/tk1_regmap_pkg.sv
common/tk1_cpu_pkg.sv
tk1_api/tk1_api.sv
rtl/tk1_security_monitor.sv
rtl/tk1_trap_led.sv
rtl/tk1_top.sv
verification/tk1_properties.sv
verification/tb_tk1.sv

//--- verification/tb_tk1.sv
/* Testbench for tk1_top with a 4-bit blink counter, so red toggles every
   16 cycles. Sticky trap and mode flags are cleared by reset between groups. */
`default_nettype none

module tb_tk1;
  timeunit 1ns;
  timeprecision 1ps;

  import tk1_regmap_pkg::*;
  import tk1_cpu_pkg::*;

  typedef struct packed {
    logic      rst;       // Reset pulse instead of a bus cycle
    logic      cs;
    logic      we;
    reg_addr_t addr;
    word_t     wdata;
    logic      valid;
    logic      instr;
    cpu_addr_t caddr;
    logic      chk;       // Compare read_data
    word_t     exp_rd;
    logic      exp_trap;
  } row_t;

  logic           clk = 1'b0;
  logic           fw_app_mode_rst;
  logic           cpu_trap, cpu_valid, cpu_instr;
  cpu_addr_t      cpu_addr;
  logic           gpio1, gpio2, cs, we;
  reg_addr_t      address;
  word_t          write_data;
  logic           fw_app_mode, force_trap, led_r, led_g, led_b, gpio3, gpio4, ready;
  ram_rand_addr_t ram_addr_rand;
  word_t          ram_data_rand, read_data;

  row_t        rows [$];
  logic        trap_model;   // Expected force_trap before the next edge
  logic        table_ready = 1'b0;
  int          checks = 0, value_errs = 0, other_errs = 0;
  int unsigned seed = 32'h3deb;
  word_t       lk_val [12];
  word_t       rnd;
  logic        red_hi, red_lo;

  tk1_top #(.trap_blink_width(4)) u_dut (.*);

  always #4 clk = ~clk;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // ------------------------------------------------------------------------
  // Table construction
  // ------------------------------------------------------------------------
  task automatic append(input logic rst, input logic c, input logic w, input reg_addr_t a,
                        input word_t d, input logic v, input logic i, input cpu_addr_t ca,
                        input logic chk, input word_t e);
    rows.push_back('{rst, c, w, a, d, v, i, ca, chk, e, trap_model});
  endtask

  task automatic write_row(input reg_addr_t a, input word_t d);
    append(1'b0, 1'b1, 1'b1, a, d, 1'b0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic read_row(input reg_addr_t a, input word_t e);
    append(1'b0, 1'b1, 1'b0, a, '0, 1'b0, 1'b0, '0, 1'b1, e);
  endtask

  task automatic fetch_row(input logic instr, input cpu_addr_t ca, input logic traps);
    append(1'b0, 1'b0, 1'b0, '0, '0, 1'b1, instr, ca, 1'b0, '0);
    if (traps) begin
      trap_model = 1'b1;   // Seen from the following row on
    end
  endtask

  // Switch-app write together with an instruction fetch at ca
  task automatic switch_row(input cpu_addr_t ca);
    append(1'b0, 1'b1, 1'b1, addr_switch_app, 32'h1, 1'b1, 1'b1, ca, 1'b0, '0);
  endtask

  task automatic reset_row();
    append(1'b1, 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b0, '0);
    trap_model = 1'b0;
  endtask

  // App start, app size, CDI words, then both seeds
  function automatic reg_addr_t locked_addr(input int i);
    if (i < 2) begin
      return reg_addr_t'(addr_app_start + i);
    end else if (i < 10) begin
      return reg_addr_t'(addr_cdi_first + i - 2);
    end
    return reg_addr_t'(addr_ram_addr_rand + i - 10);
  endfunction

  function automatic word_t readback_of(input int i);
    if (locked_addr(i) == addr_ram_addr_rand) begin
      return lk_val[i] & 32'h7fff;   // 15-bit seed
    end
    return lk_val[i];
  endfunction

  task automatic build_table();
    trap_model = 1'b0;
    read_row(addr_name0, tk1_name0);
    read_row(addr_name1, tk1_name1);
    read_row(addr_version, tk1_version);
    read_row(8'h03, '0);
    read_row(8'h30, '0);
    fetch_row(1'b0, 32'h0000_0010, 1'b0);   // Idle bus keeps ready low

    for (int i = 0; i < 12; i++) begin
      lk_val[i] = $urandom();
      write_row(locked_addr(i), lk_val[i]);
    end
    for (int i = 0; i < 12; i++) read_row(locked_addr(i), readback_of(i));
    switch_row(32'h0000_0200);
    read_row(addr_switch_app, 32'h0);
    for (int i = 0; i < 12; i++) write_row(locked_addr(i), $urandom());
    for (int i = 0; i < 12; i++) read_row(locked_addr(i), readback_of(i));

    reset_row();
    switch_row(32'h4000_0100);              // RAM fetch keeps the mode
    read_row(addr_switch_app, 32'h1);
    switch_row(32'h0000_0100);
    read_row(addr_switch_app, 32'h0);

    reset_row();
    fetch_row(1'b0, 32'h4001_fffc, 1'b0);
    fetch_row(1'b0, 32'h4002_0000, 1'b1);   // Above physical RAM
    read_row(addr_version, tk1_version);
    read_row(addr_version, tk1_version);

    reset_row();
    fetch_row(1'b0, 32'hd000_0400, 1'b0);
    fetch_row(1'b1, 32'hd000_0400, 1'b1);   // Execute from firmware RAM
    read_row(addr_name0, tk1_name0);
    read_row(addr_name0, tk1_name0);

    reset_row();
    write_row(addr_cpu_mon_first, 32'h4000_1000);
    write_row(addr_cpu_mon_last, 32'h4000_1fff);
    fetch_row(1'b1, 32'h4000_1800, 1'b0);   // Window not enabled yet
    write_row(addr_cpu_mon_ctrl, 32'h1);
    write_row(addr_cpu_mon_first, 32'h4000_8000);
    write_row(addr_cpu_mon_last, 32'h4000_9000);
    read_row(addr_cpu_mon_first, 32'h4000_1000);
    read_row(addr_cpu_mon_last, 32'h4000_1fff);
    read_row(addr_cpu_mon_ctrl, 32'h1);
    fetch_row(1'b0, 32'h4000_1800, 1'b0);
    fetch_row(1'b1, 32'h4000_2000, 1'b0);
    fetch_row(1'b1, 32'h4000_1800, 1'b1);
    read_row(addr_version, tk1_version);
    read_row(addr_version, tk1_version);
  endtask

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  task automatic pulse_reset();
    @(negedge clk);
    fw_app_mode_rst = 1'b1;
    cs = 1'b0;
    cpu_valid = 1'b0;
    repeat (2) @(negedge clk);
    fw_app_mode_rst = 1'b0;
  endtask

  task automatic bus_op(input logic c, input logic w, input reg_addr_t a, input word_t d);
    @(negedge clk);
    cs = c;
    we = w;
    address = a;
    write_data = d;
    cpu_valid = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    if (r.rst) begin
      pulse_reset();
    end else begin
      bus_op(r.cs, r.we, r.addr, r.wdata);
      cpu_valid = r.valid;
      cpu_instr = r.instr;
      cpu_addr = r.caddr;
      #2;
      check_word("ready", ready, r.cs);
      check_word("force_trap", force_trap, r.exp_trap);
      if (r.chk) check_word("read_data", read_data, r.exp_rd);
      if (r.chk && r.addr == addr_switch_app) begin
        check_word("fw_app_mode", fw_app_mode, r.exp_rd[0]);
      end
      if (r.chk && r.addr == addr_ram_addr_rand) begin
        check_word("ram_addr_rand", ram_addr_rand, r.exp_rd);
      end
      if (r.chk && r.addr == addr_ram_data_rand) begin
        check_word("ram_data_rand", ram_data_rand, r.exp_rd);
      end
    end
  endtask

  initial begin
    fw_app_mode_rst = 1'b1;
    {cpu_trap, cpu_valid, cpu_instr, gpio1, gpio2, cs, we} = '0;
    cpu_addr = '0;
    address = '0;
    write_data = '0;
    rnd = $urandom(seed);
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    fw_app_mode_rst = 1'b0;

    foreach (rows[i]) apply_row(rows[i]);

    // LED register and pins
    pulse_reset();
    #2;
    check_word("led", {led_r, led_g, led_b}, led_reset_value);
    rnd = $urandom();
    bus_op(1'b1, 1'b1, addr_led, rnd);
    bus_op(1'b0, 1'b0, addr_name0, '0);
    #2;
    check_word("led", {led_r, led_g, led_b}, rnd[2:0]);
    rnd = ~rnd;     // Every LED bit changes
    bus_op(1'b1, 1'b1, addr_led, rnd);
    bus_op(1'b0, 1'b0, addr_name0, '0);
    #2;
    check_word("led", {led_r, led_g, led_b}, rnd[2:0]);

    // GPIO bits 1:0 drive the input pins and 3:2 the outputs
    repeat (4) begin
      rnd = $urandom() & 32'hf;
      bus_op(1'b1, 1'b1, addr_gpio, rnd);
      gpio1 = rnd[0];
      gpio2 = rnd[1];
      repeat (2) @(posedge clk);
      bus_op(1'b1, 1'b0, addr_gpio, '0);
      #2;
      check_word("gpio3", gpio3, rnd[2]);
      check_word("gpio4", gpio4, rnd[3]);
      check_word("read_data", read_data, rnd);
    end

    // Blink pattern during a CPU trap
    @(negedge clk);
    cpu_trap = 1'b1;
    red_hi = 1'b0;
    red_lo = 1'b0;
    repeat (40) begin
      @(negedge clk);
      #2;
      if (led_r) begin
        red_hi = 1'b1;
      end else begin
        red_lo = 1'b1;
      end
      check_word("led_g", led_g, 1'b0);
      check_word("led_b", led_b, 1'b0);
    end
    if (!(red_hi && red_lo)) begin
      other_errs++;
      $display("Red LED did not blink within 40 cycles of the CPU trap");
    end

    $display("Checks %0d, value errors %0d, other errors %0d",
             checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog allows three cycles per row plus the LED tests
  initial begin
    wait (table_ready);
    #((rows.size() * 3 + 150) * 8);
    $display("Timeout: the tests did not complete within the time limit");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tk1_properties.sv
/* Bound into tk1_top. Checks the combinational ready and that the trap
   and mode flags change against their sticky direction only by reset. */
`default_nettype none

module tk1_properties (
  input logic clk,
  input logic fw_app_mode_rst,
  input logic cs,
  input logic ready,
  input logic force_trap,
  input logic fw_app_mode
);
  timeunit 1ns;
  timeprecision 1ps;

  // No wait states on the register bus
  ready_follows_cs: assert property (@(posedge clk) ready == cs)
    else $error("ready differs from cs");

  // A trap request is held until reset
  trap_sticky: assert property (@(posedge clk) $fell(force_trap) |-> $past(fw_app_mode_rst))
    else $error("force_trap fell without reset");

  // Back to firmware mode only by reset
  mode_one_way: assert property (@(posedge clk) $rose(fw_app_mode) |-> $past(fw_app_mode_rst))
    else $error("fw_app_mode rose without reset");

endmodule

bind tk1_top tk1_properties u_properties (
  .clk             (clk),
  .fw_app_mode_rst (fw_app_mode_rst),
  .cs              (cs),
  .ready           (ready),
  .force_trap      (force_trap),
  .fw_app_mode     (fw_app_mode)
);

`default_nettype wire

//--- rtl/tk1_top.sv
/* tk1 control core top. Bus ready is combinational, no wait states.
   trap_blink_width sets the LED blink period during a CPU trap. */
`default_nettype none

module tk1_top #(
  parameter int trap_blink_width = 24
) (
  input  logic                         clk,
  input  logic                         fw_app_mode_rst,

  input  logic                         cpu_trap,
  input  logic                         cpu_valid,
  input  logic                         cpu_instr,
  input  tk1_cpu_pkg::cpu_addr_t       cpu_addr,

  input  logic                         gpio1,
  input  logic                         gpio2,

  input  logic                         cs,
  input  logic                         we,
  input  tk1_regmap_pkg::reg_addr_t    address,
  input  tk1_regmap_pkg::word_t        write_data,

  output logic                         fw_app_mode,
  output logic                         force_trap,
  output tk1_cpu_pkg::ram_rand_addr_t  ram_addr_rand,
  output tk1_regmap_pkg::word_t        ram_data_rand,
  output logic                         led_r,
  output logic                         led_g,
  output logic                         led_b,
  output logic                         gpio3,
  output logic                         gpio4,
  output tk1_regmap_pkg::word_t        read_data,
  output logic                         ready
);

  import tk1_regmap_pkg::*;
  import tk1_cpu_pkg::*;

  logic      switch_app;
  logic      cpu_mon_en;
  cpu_addr_t cpu_mon_first;
  cpu_addr_t cpu_mon_last;
  led_t      led_level;

  tk1_api u_api (
    .clk             (clk),
    .fw_app_mode_rst (fw_app_mode_rst),
    .cs              (cs),
    .we              (we),
    .address         (address),
    .write_data      (write_data),
    .gpio1           (gpio1),
    .gpio2           (gpio2),
    .fw_app_mode     (fw_app_mode),
    .read_data       (read_data),
    .ready           (ready),
    .switch_app      (switch_app),
    .led_level       (led_level),
    .gpio3           (gpio3),
    .gpio4           (gpio4),
    .ram_addr_rand   (ram_addr_rand),
    .ram_data_rand   (ram_data_rand),
    .cpu_mon_en      (cpu_mon_en),
    .cpu_mon_first   (cpu_mon_first),
    .cpu_mon_last    (cpu_mon_last)
  );

  tk1_security_monitor u_security_monitor (
    .clk             (clk),
    .fw_app_mode_rst (fw_app_mode_rst),
    .cpu_valid       (cpu_valid),
    .cpu_instr       (cpu_instr),
    .cpu_addr        (cpu_addr),
    .switch_app      (switch_app),
    .cpu_mon_en      (cpu_mon_en),
    .cpu_mon_first   (cpu_mon_first),
    .cpu_mon_last    (cpu_mon_last),
    .fw_app_mode     (fw_app_mode),
    .force_trap      (force_trap)
  );

  tk1_trap_led #(
    .trap_blink_width (trap_blink_width)
  ) u_trap_led (
    .clk             (clk),
    .fw_app_mode_rst (fw_app_mode_rst),
    .cpu_trap        (cpu_trap),
    .led_level       (led_level),
    .led_r           (led_r),
    .led_g           (led_g),
    .led_b           (led_b)
  );

endmodule

`default_nettype wire

//--- rtl/tk1_trap_led.sv
/* LED source select. During cpu_trap red blinks with a half period of
   2**trap_blink_width cycles, green and blue stay off. */
`default_nettype none

module tk1_trap_led #(
  parameter int trap_blink_width = 24
) (
  input  logic                  clk,
  input  logic                  fw_app_mode_rst,
  input  logic                  cpu_trap,
  input  tk1_regmap_pkg::led_t  led_level,
  output logic                  led_r,
  output logic                  led_g,
  output logic                  led_b
);

  import tk1_regmap_pkg::*;

  logic [trap_blink_width-1:0] blink_ctr;  // Free running
  led_t                        blink_led;
  led_t                        muxed_led;

  always_ff @(posedge clk) begin
    if (fw_app_mode_rst) begin
      blink_ctr <= '0;
      blink_led <= '0;
    end else begin
      blink_ctr <= blink_ctr + trap_blink_width'(1);
      if (blink_ctr == '0) begin
        blink_led[led_r_bit] <= ~blink_led[led_r_bit]; // Toggle on wrap
      end
    end
  end

  assign muxed_led = cpu_trap ? blink_led : led_level;

  assign led_r = muxed_led[led_r_bit];
  assign led_g = muxed_led[led_g_bit];
  assign led_b = muxed_led[led_b_bit];

endmodule

`default_nettype wire

//--- rtl/tk1_security_monitor.sv
/* Access checks on the CPU bus. force_trap and the cleared mode are
   sticky and only fw_app_mode_rst restores them. */
`default_nettype none

module tk1_security_monitor (
  input  logic                    clk,
  input  logic                    fw_app_mode_rst,

  input  logic                    cpu_valid,
  input  logic                    cpu_instr,
  input  tk1_cpu_pkg::cpu_addr_t  cpu_addr,

  input  logic                    switch_app,
  input  logic                    cpu_mon_en,
  input  tk1_cpu_pkg::cpu_addr_t  cpu_mon_first,
  input  tk1_cpu_pkg::cpu_addr_t  cpu_mon_last,

  output logic                    fw_app_mode,
  output logic                    force_trap
);

  import tk1_cpu_pkg::*;

  region_prefix_t region;
  logic           ram_oob;      // Beyond physical RAM
  logic           fw_ram_exec;  // Fetch from firmware RAM
  logic           mon_exec;     // Fetch inside the data-only window
  logic           violation;
  logic           rom_fetch;

  assign region = cpu_addr[31:30];

  // --------------------------------------------------------------------------
  // Violation rules
  // --------------------------------------------------------------------------
  assign ram_oob     = (region == ram_prefix) && (|cpu_addr[29:ram_phys_bits]);
  assign fw_ram_exec = cpu_instr &&
                       (cpu_addr >= fw_ram_first) && (cpu_addr <= fw_ram_last);
  assign mon_exec    = cpu_instr && cpu_mon_en &&
                       (cpu_addr >= cpu_mon_first) && (cpu_addr <= cpu_mon_last);

  assign violation = cpu_valid && (ram_oob || fw_ram_exec || mon_exec);

  // Only code running from ROM may leave firmware mode
  assign rom_fetch = cpu_valid && cpu_instr && (region == rom_prefix);

  always_ff @(posedge clk) begin
    if (fw_app_mode_rst) begin
      force_trap  <= 1'b0;
      fw_app_mode <= 1'b1;
    end else begin
      if (violation) begin
        force_trap <= 1'b1;
      end
      if (switch_app && rom_fetch) begin
        fw_app_mode <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tk1_api/tk1_api.sv
/* Register file of the tk1 core. App, CDI and seed registers accept writes
   in firmware mode only. The monitor window locks once it is enabled.
   gpio1 and gpio2 read back two clock edges after the pins. */
`default_nettype none

module tk1_api (
  input  logic                         clk,
  input  logic                         fw_app_mode_rst,

  input  logic                         cs,
  input  logic                         we,
  input  tk1_regmap_pkg::reg_addr_t    address,
  input  tk1_regmap_pkg::word_t        write_data,

  input  logic                         gpio1,
  input  logic                         gpio2,
  input  logic                         fw_app_mode,

  output tk1_regmap_pkg::word_t        read_data,
  output logic                         ready,
  output logic                         switch_app,
  output tk1_regmap_pkg::led_t         led_level,
  output logic                         gpio3,
  output logic                         gpio4,
  output tk1_cpu_pkg::ram_rand_addr_t  ram_addr_rand,
  output tk1_regmap_pkg::word_t        ram_data_rand,
  output logic                         cpu_mon_en,
  output tk1_cpu_pkg::cpu_addr_t       cpu_mon_first,
  output tk1_cpu_pkg::cpu_addr_t       cpu_mon_last
);

  import tk1_regmap_pkg::*;
  import tk1_cpu_pkg::*;

  word_t      app_start;
  word_t      app_size;
  word_t      cdi_mem [8];
  logic [1:0] gpio1_sync;     // [1] is the stable sample
  logic [1:0] gpio2_sync;

  logic       wr;
  logic       rd;
  logic       cdi_hit;
  word_t      gpio_word;

  assign ready   = cs;
  assign wr      = cs & we;
  assign rd      = cs & ~we;
  assign cdi_hit = (address >= addr_cdi_first) && (address <= addr_cdi_last);

  // Pulse towards the security monitor, qualified there by the fetch
  assign switch_app = wr && (address == addr_switch_app);

  // --------------------------------------------------------------------------
  // Register updates
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (fw_app_mode_rst) begin
      led_level     <= led_reset_value;
      gpio1_sync    <= '0;
      gpio2_sync    <= '0;
      gpio3         <= 1'b0;
      gpio4         <= 1'b0;
      app_start     <= '0;
      app_size      <= '0;
      ram_addr_rand <= '0;
      ram_data_rand <= '0;
      cpu_mon_en    <= 1'b0;
      cpu_mon_first <= '0;
      cpu_mon_last  <= '0;
    end else begin
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};

      if (wr) begin
        case (address)
          addr_led: led_level <= write_data[2:0];
          addr_gpio: begin
            gpio3 <= write_data[gpio3_bit];
            gpio4 <= write_data[gpio4_bit];
          end
          addr_app_start: if (fw_app_mode) app_start <= write_data;
          addr_app_size:  if (fw_app_mode) app_size  <= write_data;
          addr_ram_addr_rand: begin
            if (fw_app_mode) begin
              ram_addr_rand <= write_data[14:0];
            end
          end
          addr_ram_data_rand: if (fw_app_mode) ram_data_rand <= write_data;
          addr_cpu_mon_ctrl:  cpu_mon_en <= 1'b1; // Sticky until reset
          addr_cpu_mon_first: if (!cpu_mon_en) cpu_mon_first <= write_data;
          addr_cpu_mon_last:  if (!cpu_mon_en) cpu_mon_last  <= write_data;
          default: ;
        endcase
      end
    end
  end

  // CDI words, written by firmware before the app starts
  always_ff @(posedge clk) begin
    if (wr && cdi_hit && fw_app_mode) begin
      cdi_mem[address[2:0]] <= write_data;
    end
  end

  // --------------------------------------------------------------------------
  // Read multiplexer
  // --------------------------------------------------------------------------
  always_comb begin
    gpio_word            = '0;
    gpio_word[gpio1_bit] = gpio1_sync[1];
    gpio_word[gpio2_bit] = gpio2_sync[1];
    gpio_word[gpio3_bit] = gpio3;
    gpio_word[gpio4_bit] = gpio4;
  end

  always_comb begin
    read_data = '0; // Unmapped reads return zero
    if (rd) begin
      case (address)
        addr_name0:         read_data = tk1_name0;
        addr_name1:         read_data = tk1_name1;
        addr_version:       read_data = tk1_version;
        addr_switch_app:    read_data = {31'h0, fw_app_mode};
        addr_led:           read_data = {29'h0, led_level};
        addr_gpio:          read_data = gpio_word;
        addr_app_start:     read_data = app_start;
        addr_app_size:      read_data = app_size;
        addr_ram_addr_rand: read_data = {17'h0, ram_addr_rand};
        addr_ram_data_rand: read_data = ram_data_rand;
        addr_cpu_mon_ctrl:  read_data = {31'h0, cpu_mon_en};
        addr_cpu_mon_first: read_data = cpu_mon_first;
        addr_cpu_mon_last:  read_data = cpu_mon_last;
        default: begin
          if (cdi_hit) begin
            read_data = cdi_mem[address[2:0]];
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- common/tk1_cpu_pkg.sv
/* CPU bus types and memory map used by the security checks.
   The top two address bits select the memory region. */
`default_nettype none

package tk1_cpu_pkg;

  typedef logic [31:0] cpu_addr_t;      // CPU byte address
  typedef logic [14:0] ram_rand_addr_t; // RAM address scrambling seed
  typedef logic [1:0]  region_prefix_t; // cpu_addr[31:30]

  // --------------------------------------------------------------------------
  // Memory regions
  // --------------------------------------------------------------------------
  localparam region_prefix_t rom_prefix = 2'h0;
  localparam region_prefix_t ram_prefix = 2'h1;

  // Physical RAM is 128 KiB, bits 17..29 must stay clear in the RAM region
  localparam int ram_phys_bits = 17;

  // Firmware scratch RAM, never executable
  localparam cpu_addr_t fw_ram_first = 32'hd0000000;
  localparam cpu_addr_t fw_ram_last  = 32'hd00007ff;

endpackage

`default_nettype wire

//--- common/tk1_regmap_pkg.sv
/* Register map and identity words of the tk1 control core.
   All addresses are word addresses on the 8-bit register bus. */
`default_nettype none

package tk1_regmap_pkg;

  typedef logic [31:0] word_t;     // Bus data word
  typedef logic [7:0]  reg_addr_t; // Register word address
  typedef logic [2:0]  led_t;      // {red, green, blue}

  // --------------------------------------------------------------------------
  // Register addresses
  // --------------------------------------------------------------------------
  localparam reg_addr_t addr_name0         = 8'h00;
  localparam reg_addr_t addr_name1         = 8'h01;
  localparam reg_addr_t addr_version       = 8'h02;

  localparam reg_addr_t addr_switch_app    = 8'h08;
  localparam reg_addr_t addr_led           = 8'h09;
  localparam reg_addr_t addr_gpio          = 8'h0a;

  localparam reg_addr_t addr_app_start     = 8'h0c;
  localparam reg_addr_t addr_app_size      = 8'h0d;

  localparam reg_addr_t addr_cdi_first     = 8'h20;
  localparam reg_addr_t addr_cdi_last      = 8'h27;

  localparam reg_addr_t addr_ram_addr_rand = 8'h40;
  localparam reg_addr_t addr_ram_data_rand = 8'h41;

  localparam reg_addr_t addr_cpu_mon_ctrl  = 8'h60;
  localparam reg_addr_t addr_cpu_mon_first = 8'h61;
  localparam reg_addr_t addr_cpu_mon_last  = 8'h62;

  // Identity words
  localparam word_t tk1_name0   = 32'h746b3120; // "tk1 "
  localparam word_t tk1_name1   = 32'h6d6b6466; // "mkdf"
  localparam word_t tk1_version = 32'h00000005;

  // GPIO register bit positions
  localparam int gpio1_bit = 0;
  localparam int gpio2_bit = 1;
  localparam int gpio3_bit = 2;
  localparam int gpio4_bit = 3;

  // LED bit positions inside led_t
  localparam int led_r_bit = 2;
  localparam int led_g_bit = 1;
  localparam int led_b_bit = 0;

  localparam led_t led_reset_value = 3'h6;

endpackage

`default_nettype wire
